// ==== filelist.f ====
verilog/fir_pkg.sv
verilog/ahb_lite_slave.sv
verilog/coefficient_loader.sv
verilog/fir_filter.sv
verilog/ahb_lite_fir_filter.sv
sim/tb_ahb_lite_fir_filter_assert.sv
sim/tb_ahb_lite_fir_filter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FIR filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ahb_lite_fir_filter \
    -f filelist.f \
    -o tb_ahb_lite_fir_filter

./obj_dir/tb_ahb_lite_fir_filter

// ==== sim/tb_ahb_lite_fir_filter.sv ====
`default_nettype none

module tb_ahb_lite_fir_filter import fir_pkg::*; ();

    localparam int POLL_LIMIT = 50;
    // nonsequential transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    logic clk;
    logic n_rst;
    logic hsel;
    logic [3:0] haddr;
    logic hsize;
    logic [1:0] htrans;
    logic hwrite;
    logic [DATA_W-1:0] hwdata;
    logic [DATA_W-1:0] hrdata;
    logic hresp;

    // reference model
    logic [DATA_W-1:0] model_coef [NUM_TAPS];
    logic [DATA_W-1:0] model_taps [NUM_TAPS];
    logic [DATA_W-1:0] model_out;
    logic model_err;

    ahb_lite_fir_filter i_dut (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // coefficient k as a halfword at 6 + 2k
    function automatic logic [3:0] coef_addr(input int k);
        return ADDR_COEF0 + 4'(2 * k);
    endfunction

    // address phase, then data phase, inputs change on the falling edge
    task automatic transfer(input logic write, input logic [3:0] addr, input logic size,
                            input logic [DATA_W-1:0] wdata, input logic exp_resp,
                            output logic [DATA_W-1:0] rdata);
        @(negedge clk);
        hsel = 1'b1;
        haddr = addr;
        hsize = size;
        htrans = HTRANS_NONSEQ;
        hwrite = write;
        // hresp only depends on the address phase inputs
        @(posedge clk);
        assert (hresp == exp_resp) else begin
            $display("Error: hresp at address %h is %h, expected %h", addr, hresp, exp_resp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
        @(negedge clk);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = wdata;
        rdata = hrdata;
        @(posedge clk);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic size,
                             input logic [DATA_W-1:0] data, input logic exp_resp);
        logic [DATA_W-1:0] unused_rdata;
        transfer(1'b1, addr, size, data, exp_resp, unused_rdata);
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic size,
                            input logic [DATA_W-1:0] expected, input logic exp_resp);
        logic [DATA_W-1:0] value;
        transfer(1'b0, addr, size, '0, exp_resp, value);
        assert (value == expected) else begin
            $display("Error: hrdata at address %h is %h, expected %h", addr, value, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // poll the busy byte until it reads the target
    task automatic wait_status(input logic [7:0] target);
        logic [DATA_W-1:0] value;
        int polls;
        polls = 1;
        transfer(1'b0, ADDR_STATUS, 1'b0, '0, 1'b0, value);
        while ((value[7:0] != target) && (polls < POLL_LIMIT)) begin
            transfer(1'b0, ADDR_STATUS, 1'b0, '0, 1'b0, value);
            polls++;
        end
        if (value[7:0] != target) begin
            $display("Timeout: status byte did not reach %0d within %0d polls",
                     target, POLL_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // newest sample into tap 0, sum of coef times tap, drop 15 fraction bits
    task automatic model_push(input logic [DATA_W-1:0] sample);
        logic [33:0] acc;
        acc = '0;
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
            model_taps[k] = model_taps[k-1];
        end
        model_taps[0] = sample;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc = acc + 34'(model_coef[k]) * 34'(model_taps[k]);
        end
        model_out = acc[30:15];
        // anything left above the 16 result bits
        model_err = |acc[33:31];
    endtask

    // write F0..F3 from the model, request a reload, wait it out
    task automatic load_coefficients();
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(coef_addr(k), 1'b1, model_coef[k], 1'b0);
        end
        write_reg(ADDR_NEW_COEF, 1'b0, 16'h0001, 1'b0);
        // busy shows right after the request
        read_reg(ADDR_STATUS, 1'b0, 16'h0001, 1'b0);
        wait_status(8'd0);
        read_reg(ADDR_NEW_COEF, 1'b1, 16'h0000, 1'b0);
    endtask

    task automatic run_sample(input logic [DATA_W-1:0] sample);
        write_reg(ADDR_SAMPLE, 1'b1, sample, 1'b0);
        model_push(sample);
        // busy rises a couple of cycles after the write
        wait_status(8'd1);
        wait_status(8'd0);
        read_reg(ADDR_RESULT, 1'b1, model_out, 1'b0);
        // error byte is odd so it comes back on the upper lane
        read_reg(ADDR_ERROR, 1'b0, {7'b0, model_err, 8'h00}, 1'b0);
    endtask

    initial begin
        logic [DATA_W-1:0] word;

        void'($urandom(32'h4497));
        n_rst = 1'b0;
        hsel = 1'b0;
        haddr = '0;
        hsize = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            model_coef[k] = '0;
            model_taps[k] = '0;
        end
        model_out = '0;
        model_err = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // halfword write to F0, read back whole and per byte
        word = 16'($urandom);
        write_reg(coef_addr(0), 1'b1, word, 1'b0);
        read_reg(coef_addr(0), 1'b1, word, 1'b0);
        read_reg(coef_addr(0), 1'b0, {8'h00, word[7:0]}, 1'b0);
        read_reg(coef_addr(0) + 4'd1, 1'b0, {word[15:8], 8'h00}, 1'b0);
        // F1 never written
        read_reg(coef_addr(1), 1'b1, 16'h0000, 1'b0);
        // F2 by bytes, junk on the lane not selected
        write_reg(coef_addr(2), 1'b0, 16'hEE34, 1'b0);
        write_reg(coef_addr(2) + 4'd1, 1'b0, 16'h12EE, 1'b0);
        read_reg(coef_addr(2), 1'b1, 16'h1234, 1'b0);
        // F3 low byte only
        write_reg(coef_addr(3), 1'b0, 16'hCC5A, 1'b0);
        read_reg(coef_addr(3), 1'b1, 16'h005A, 1'b0);
        read_reg(coef_addr(3) + 4'd1, 1'b0, 16'h0000, 1'b0);

        // status and result bytes are read only
        for (int a = 0; a < 4; a++) begin
            write_reg(4'(a), 1'b0, 16'hFFFF, 1'b1);
        end
        write_reg(ADDR_RESULT, 1'b1, 16'hFFFF, 1'b1);
        read_reg(ADDR_STATUS, 1'b1, 16'h0000, 1'b0);
        read_reg(ADDR_RESULT, 1'b1, 16'h0000, 1'b0);
        // byte 15 refused both ways
        write_reg(4'd15, 1'b0, 16'hFFFF, 1'b1);
        read_reg(4'd15, 1'b0, 16'h0000, 1'b1);
        read_reg(ADDR_NEW_COEF, 1'b1, 16'h0000, 1'b0);
        read_reg(coef_addr(0), 1'b1, word, 1'b0);

        // random coefficients below 0.5 and samples below 2^15 never overflow
        for (int k = 0; k < NUM_TAPS; k++) begin
            model_coef[k] = 16'($urandom & 32'h3FFF);
        end
        load_coefficients();
        for (int n = 0; n < 20; n++) begin
            run_sample(16'($urandom & 32'h7FFF));
        end

        // unity gain on every tap with full scale input
        for (int k = 0; k < NUM_TAPS; k++) begin
            model_coef[k] = 16'h8000;
        end
        load_coefficients();
        for (int n = 0; n < NUM_TAPS; n++) begin
            run_sample(16'hFFFF);
        end
        read_reg(ADDR_ERROR, 1'b0, 16'h0100, 1'b0);
        // only tap 0 left, err holds through the reload
        model_coef[0] = 16'h8000;
        for (int k = 1; k < NUM_TAPS; k++) begin
            model_coef[k] = 16'h0000;
        end
        load_coefficients();
        read_reg(ADDR_ERROR, 1'b0, 16'h0100, 1'b0);
        run_sample(16'h0123);
        read_reg(ADDR_ERROR, 1'b0, 16'h0000, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_ahb_lite_fir_filter_assert.sv ====
`default_nettype none

module fir_bus_assert import fir_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        hsel,
    input  logic [3:0]  haddr,
    input  logic        hsize,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic        hresp,
    input  logic        data_ready,
    input  logic        modwait,
    input  logic        load_coeff,
    input  logic        coeff_busy,
    input  logic        err
);

    logic expect_hresp;
    logic accepted;
    // bit k set when a sample was taken k+1 cycles ago
    logic [5:0] accept_hist;
    // load strobes seen back to back so far
    logic [2:0] load_run;

    // writes to status or result, or a byte access to byte 15
    assign expect_hresp = hsel && (htrans != HTRANS_IDLE) &&
                          ((hwrite && (haddr < ADDR_SAMPLE)) ||
                           (!hsize && (haddr == 4'd15)));

    // filter idle and loader quiet
    assign accepted = data_ready && !modwait && !coeff_busy;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            accept_hist <= '0;
            load_run <= '0;
        end else begin
            accept_hist <= {accept_hist[4:0], accepted};
            load_run <= load_coeff ? load_run + 3'd1 : 3'd0;
        end
    end

    hresp_rule: assert property (@(posedge clk) disable iff (!n_rst)
        hresp == expect_hresp)
        else $error("hresp does not follow the address phase");

    // shift plus four MAC cycles
    busy_while_filtering: assert property (@(posedge clk) disable iff (!n_rst)
        (|accept_hist[4:0]) |-> modwait)
        else $error("modwait dropped before the result was done");

    busy_ends_on_time: assert property (@(posedge clk) disable iff (!n_rst)
        accept_hist[5] |-> !modwait)
        else $error("modwait still high six cycles after the sample was taken");

    // one strobe per tap
    load_run_max: assert property (@(posedge clk) disable iff (!n_rst)
        load_coeff |-> (load_run < 3'd4))
        else $error("more than four load strobes in a row");

    load_run_len: assert property (@(posedge clk) disable iff (!n_rst)
        (!load_coeff && (load_run != 3'd0)) |-> (load_run == 3'd4))
        else $error("load strobe run ended short of four");

    reset_quiet: assert property (@(posedge clk)
        !n_rst |-> !(data_ready || modwait || err || load_coeff || coeff_busy || hresp))
        else $error("control output active during reset");

endmodule

bind ahb_lite_fir_filter fir_bus_assert i_assert (
    .clk        (clk),
    .n_rst      (n_rst),
    .hsel       (hsel),
    .haddr      (haddr),
    .hsize      (hsize),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hresp      (hresp),
    .data_ready (data_ready),
    .modwait    (modwait),
    .load_coeff (load_coeff),
    .coeff_busy (coeff_busy),
    .err        (err)
);

`default_nettype wire

// ==== verilog/ahb_lite_fir_filter.sv ====
`default_nettype none

module ahb_lite_fir_filter import fir_pkg::*; (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                hsel,
    input  logic [3:0]          haddr,
    input  logic                hsize,
    input  logic [1:0]          htrans,
    input  logic                hwrite,
    input  logic [DATA_W-1:0]   hwdata,
    output logic [DATA_W-1:0]   hrdata,
    output logic                hresp
);

    // slave to filter
    logic [DATA_W-1:0] sample_data;
    logic data_ready;
    logic [DATA_W-1:0] fir_coefficient;
    // slave to loader
    logic new_coefficient_set;
    // loader to slave and filter
    logic [1:0] coefficient_num;
    logic load_coeff;
    logic coeff_busy;
    // filter back to the status bytes
    logic modwait;
    logic [DATA_W-1:0] fir_out;
    logic err;

    ahb_lite_slave i_slave (
        .clk                 (clk),
        .n_rst               (n_rst),
        .hsel                (hsel),
        .haddr               (haddr),
        .hsize               (hsize),
        .htrans              (htrans),
        .hwrite              (hwrite),
        .hwdata              (hwdata),
        .coefficient_num     (coefficient_num),
        .modwait             (modwait),
        .fir_out             (fir_out),
        .err                 (err),
        .hrdata              (hrdata),
        .hresp               (hresp),
        .sample_data         (sample_data),
        .data_ready          (data_ready),
        .new_coefficient_set (new_coefficient_set),
        .fir_coefficient     (fir_coefficient)
    );

    coefficient_loader i_loader (
        .clk                 (clk),
        .n_rst               (n_rst),
        .new_coefficient_set (new_coefficient_set),
        .coefficient_num     (coefficient_num),
        .load_coeff          (load_coeff),
        .coeff_busy          (coeff_busy)
    );

    fir_filter i_filter (
        .clk             (clk),
        .n_rst           (n_rst),
        .data_ready      (data_ready),
        .sample_data     (sample_data),
        .fir_coefficient (fir_coefficient),
        .coefficient_num (coefficient_num),
        .load_coeff      (load_coeff),
        .coeff_busy      (coeff_busy),
        .modwait         (modwait),
        .fir_out         (fir_out),
        .err             (err)
    );

endmodule

`default_nettype wire

// ==== verilog/fir_filter.sv ====
`default_nettype none

module fir_filter import fir_pkg::*; (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                data_ready,
    input  logic [DATA_W-1:0]   sample_data,
    input  logic [DATA_W-1:0]   fir_coefficient,
    input  logic [1:0]          coefficient_num,
    input  logic                load_coeff,
    input  logic                coeff_busy,
    output logic                modwait,
    output logic [DATA_W-1:0]   fir_out,
    output logic                err
);

    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam int PROD_W = 2 * DATA_W;
    // room for the sum of NUM_TAPS full products
    localparam int ACC_W = PROD_W + IDX_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TAPS - 1);

    logic [DATA_W-1:0] coef [NUM_TAPS];
    // tap 0 holds the newest sample
    logic [DATA_W-1:0] taps [NUM_TAPS];

    fir_state_t state;
    fir_state_t next_state;
    logic [IDX_W-1:0] mac_idx;
    logic [ACC_W-1:0] acc;
    logic [PROD_W-1:0] product;
    logic overflow;

    // coefficient registers
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef[i] <= '0;
            end
        end else if (load_coeff) begin
            coef[coefficient_num] <= fir_coefficient;
        end
    end

    // controller
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= FIR_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // hold off while the loader is rewriting coefficients
            FIR_IDLE: if (data_ready && !coeff_busy) next_state = FIR_SHIFT;
            FIR_SHIFT: next_state = FIR_MAC;
            FIR_MAC: if (mac_idx == LAST_IDX) next_state = FIR_DONE;
            FIR_DONE: next_state = FIR_IDLE;
            default: next_state = FIR_IDLE;
        endcase
    end

    assign modwait = (state == FIR_SHIFT) || (state == FIR_MAC);

    // one product per MAC cycle
    assign product = coef[mac_idx] * taps[mac_idx];
    // anything above the 16 result bits after the shift
    assign overflow = |acc[ACC_W-1:FRAC_BITS+DATA_W];

    // delay line and accumulator
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps[i] <= '0;
            end
            mac_idx <= '0;
            acc <= '0;
            fir_out <= '0;
            err <= 1'b0;
        end else begin
            case (state)
                FIR_SHIFT: begin
                    taps[0] <= sample_data;
                    for (int i = 1; i < NUM_TAPS; i++) begin
                        taps[i] <= taps[i-1];
                    end
                    acc <= '0;
                    mac_idx <= '0;
                end
                FIR_MAC: begin
                    acc <= acc + ACC_W'(product);
                    mac_idx <= mac_idx + 1'b1;
                end
                FIR_DONE: begin
                    // drop the fraction bits
                    fir_out <= acc[FRAC_BITS +: DATA_W];
                    // sticky until the next clean result
                    err <= overflow;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/coefficient_loader.sv ====
`default_nettype none

module coefficient_loader import fir_pkg::*; (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        new_coefficient_set,
    output logic [1:0]  coefficient_num,
    output logic        load_coeff,
    output logic        coeff_busy
);

    localparam logic [1:0] LAST_IDX = 2'(NUM_TAPS - 1);

    ldr_state_t state;
    ldr_state_t next_state;
    logic [1:0] next_num;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= LDR_IDLE;
            coefficient_num <= '0;
        end else begin
            state <= next_state;
            coefficient_num <= next_num;
        end
    end

    always_comb begin
        next_state = state;
        next_num = coefficient_num;
        case (state)
            LDR_IDLE: begin
                next_num = '0;
                if (new_coefficient_set) begin
                    next_state = LDR_LOAD;
                end
            end
            LDR_LOAD: begin
                // index wraps back to 0 after the last tap
                next_num = coefficient_num + 2'd1;
                if (coefficient_num == LAST_IDX) begin
                    next_state = LDR_WAIT;
                end
            end
            // flag drops while we sit here
            // so one request loads only once
            LDR_WAIT: next_state = LDR_IDLE;
            default: next_state = LDR_IDLE;
        endcase
    end

    // one load strobe per index
    assign load_coeff = (state == LDR_LOAD);
    assign coeff_busy = (state != LDR_IDLE);

endmodule

`default_nettype wire

// ==== verilog/ahb_lite_slave.sv ====
`default_nettype none

module ahb_lite_slave import fir_pkg::*; (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                hsel,
    input  logic [3:0]          haddr,
    input  logic                hsize,
    input  logic [1:0]          htrans,
    input  logic                hwrite,
    input  logic [DATA_W-1:0]   hwdata,
    input  logic [1:0]          coefficient_num,
    input  logic                modwait,
    input  logic [DATA_W-1:0]   fir_out,
    input  logic                err,
    output logic [DATA_W-1:0]   hrdata,
    output logic                hresp,
    output logic [DATA_W-1:0]   sample_data,
    output logic                data_ready,
    output logic                new_coefficient_set,
    output logic [DATA_W-1:0]   fir_coefficient
);

    // 16 byte register table
    logic [15:0][7:0] reg_table;
    logic [15:0][7:0] next_table;
    logic next_data_ready;

    // address phase, held for the data phase
    logic ap_valid;
    logic ap_err;
    logic ap_write;
    logic ap_size;
    logic [3:0] ap_addr;
    logic [3:0] ap_base;

    logic bus_active;
    logic [3:0] coef_base;

    // selected and not idle
    assign bus_active = hsel && (htrans != HTRANS_IDLE);

    // error in the address phase
    // status and result bytes are read only
    // byte 15 only exists as the upper half of the flag halfword
    assign hresp = bus_active &&
                   ((hwrite && (haddr < ADDR_SAMPLE)) ||
                    (!hsize && (haddr == (ADDR_NEW_COEF + 4'd1))));

    // halfword base is the even address
    assign ap_base = {ap_addr[3:1], 1'b0};

    // plain views of the table
    assign sample_data = {reg_table[ADDR_SAMPLE + 4'd1], reg_table[ADDR_SAMPLE]};
    assign new_coefficient_set = reg_table[ADDR_NEW_COEF][0];

    // coefficient k lives at 6 + 2k
    assign coef_base = ADDR_COEF0 + {1'b0, coefficient_num, 1'b0};
    assign fir_coefficient = {reg_table[coef_base + 4'd1], reg_table[coef_base]};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            reg_table <= '0;
            data_ready <= 1'b0;
            ap_valid <= 1'b0;
            ap_err <= 1'b0;
            ap_write <= 1'b0;
            ap_size <= 1'b0;
            ap_addr <= '0;
        end else begin
            reg_table <= next_table;
            data_ready <= next_data_ready;
            ap_valid <= bus_active;
            ap_err <= hresp;
            ap_write <= hwrite;
            ap_size <= hsize;
            ap_addr <= haddr;
        end
    end

    always_comb begin
        next_table = reg_table;
        next_data_ready = data_ready;
        hrdata = '0;

        // status bytes follow the filter every cycle
        next_table[ADDR_STATUS] = {7'b0, modwait | new_coefficient_set};
        next_table[ADDR_ERROR] = {7'b0, err};
        next_table[ADDR_RESULT] = fir_out[7:0];
        next_table[ADDR_RESULT + 4'd1] = fir_out[15:8];

        // data phase
        // errored transfers leave the table alone
        if (ap_valid && !ap_err) begin
            if (ap_write) begin
                if (ap_size) begin
                    next_table[ap_base] = hwdata[7:0];
                    next_table[ap_base + 4'd1] = hwdata[15:8];
                end else if (ap_addr[0]) begin
                    // odd byte rides the upper lane
                    next_table[ap_addr] = hwdata[15:8];
                end else begin
                    next_table[ap_addr] = hwdata[7:0];
                end
                // any write to the sample halfword starts the filter
                if (ap_base == ADDR_SAMPLE) begin
                    next_data_ready = 1'b1;
                end
            end else begin
                if (ap_size) begin
                    hrdata = {reg_table[ap_base + 4'd1], reg_table[ap_base]};
                end else if (ap_addr[0]) begin
                    hrdata[15:8] = reg_table[ap_addr];
                end else begin
                    hrdata[7:0] = reg_table[ap_addr];
                end
            end
        end

        // last index presented so the reload request is done
        // wins over a host write in the same cycle
        if (coefficient_num == 2'(NUM_TAPS - 1)) begin
            next_table[ADDR_NEW_COEF] = '0;
        end

        // filter has taken the sample
        if (modwait) begin
            next_data_ready = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

    // filter geometry
    localparam int NUM_TAPS = 4;
    localparam int DATA_W = 16;
    // coefficient of 32768 is unity gain
    localparam int FRAC_BITS = 15;

    // byte addresses of the register table
    localparam logic [3:0] ADDR_STATUS = 4'd0;
    localparam logic [3:0] ADDR_ERROR = 4'd1;
    // result low byte here, high byte one above
    localparam logic [3:0] ADDR_RESULT = 4'd2;
    localparam logic [3:0] ADDR_SAMPLE = 4'd4;
    // F0 through F3 as halfwords from here up to 13
    localparam logic [3:0] ADDR_COEF0 = 4'd6;
    localparam logic [3:0] ADDR_NEW_COEF = 4'd14;

    // only idle counts as no transfer
    localparam logic [1:0] HTRANS_IDLE = 2'd0;

    // filter controller
    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_SHIFT,
        FIR_MAC,
        FIR_DONE
    } fir_state_t;

    // coefficient loader
    typedef enum logic [1:0] {
        LDR_IDLE,
        LDR_LOAD,
        LDR_WAIT
    } ldr_state_t;

endpackage

`default_nettype wire
